/* ex_macros.svh */
//////////////////////////////////////////////////////////////////////
// Widths and step counts shared by the execute stage
// Values are fixed for RV32, the multiplier split assumes
// EX_MUL_HALF_W * 2 == EX_XLEN and EX_MUL_STEPS == 4
//////////////////////////////////////////////////////////////////////

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data word width
`define EX_XLEN 32

// Register file address width, 6 bits as in the reference core
`define EX_RADDR_W 6

// One partial-product operand
`define EX_MUL_HALF_W 16

// Number of steps in a MULH / MULHU sweep
`define EX_MUL_STEPS 4

`endif

/* ex_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Types shared by the execute stage RTL
// Widths come from the macros header
//////////////////////////////////////////////////////////////////////

`include "ex_macros.svh"

package ex_pkg;

  typedef logic [`EX_XLEN-1:0]    word_t;     // One data word
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t; // Register file address

  // ALU opcodes, compare group sits at the top
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10, // Branch compares from here on
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_MUL   = 2'd0, // Low word, single cycle
    MUL_MULH  = 2'd1, // High word, signed x signed
    MUL_MULHU = 2'd2  // High word, unsigned x unsigned
  } mul_op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    STEP = 2'd1,
    DONE = 2'd2
  } mul_state_e;

  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
    word_t   operand_c; // Jump target for branches
  } alu_req_t;

  typedef struct packed {
    mul_op_e op;
    word_t   op_a;
    word_t   op_b;
  } mul_req_t;

  // One register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

  // Decode control that reaches EX
  typedef struct packed {
    logic      alu_en;
    logic      mult_en;
    logic      csr_access;
    logic      lsu_en;
    logic      branch_in_ex;
    logic      regfile_alu_we;    // Forwarding port write
    reg_addr_t regfile_alu_waddr;
    logic      regfile_we;        // Load write, goes through EX/WB
    reg_addr_t regfile_waddr;
  } id_ctrl_t;

endpackage

/* ex_alu.sv */
//////////////////////////////////////////////////////////////////////
// Single-cycle integer ALU, purely combinational
// Shift amount is operand b [4:0], operand c is not used here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o
);

  logic [4:0]    shamt;
  logic          is_eq;
  logic          lt_s;
  logic          lt_u;
  logic          cmp;
  ex_pkg::word_t sra_res;

  assign shamt = req_i.operand_b[4:0];

  // Compare primitives shared by SLT* and branches
  assign is_eq = (req_i.operand_a == req_i.operand_b);
  assign lt_s  = ($signed(req_i.operand_a) < $signed(req_i.operand_b));
  assign lt_u  = (req_i.operand_a < req_i.operand_b);

  assign sra_res = ex_pkg::word_t'($signed(req_i.operand_a) >>> shamt); // Arithmetic shift

  //////////////////////////////////////////////////////////////////////
  // Comparison bit
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ex_pkg::ALU_SLT:  cmp = lt_s;
      ex_pkg::ALU_SLTU: cmp = lt_u;
      ex_pkg::ALU_EQ:   cmp = is_eq;
      ex_pkg::ALU_NE:   cmp = ~is_eq;
      ex_pkg::ALU_LT:   cmp = lt_s;
      ex_pkg::ALU_GE:   cmp = ~lt_s;
      ex_pkg::ALU_LTU:  cmp = lt_u;
      ex_pkg::ALU_GEU:  cmp = ~lt_u;
      default:          cmp = 1'b0; // Not a compare
    endcase
  end

  assign cmp_result_o = cmp;

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ex_pkg::ALU_ADD: result_o = req_i.operand_a + req_i.operand_b;
      ex_pkg::ALU_SUB: result_o = req_i.operand_a - req_i.operand_b;
      ex_pkg::ALU_AND: result_o = req_i.operand_a & req_i.operand_b;
      ex_pkg::ALU_OR:  result_o = req_i.operand_a | req_i.operand_b;
      ex_pkg::ALU_XOR: result_o = req_i.operand_a ^ req_i.operand_b;
      ex_pkg::ALU_SLL: result_o = req_i.operand_a << shamt;
      ex_pkg::ALU_SRL: result_o = req_i.operand_a >> shamt;
      ex_pkg::ALU_SRA: result_o = sra_res;
      // SLT, SLTU and branch compares give 0 or 1
      default:         result_o = ex_pkg::word_t'(cmp);
    endcase
  end

endmodule

/* ex_mult.sv */
//////////////////////////////////////////////////////////////////////
// Multiplier, MUL is single cycle from the operands
// MULH / MULHU take 4 cycles, one 16x16 partial product per step
// Operands must stay steady until the result is taken
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_macros.svh"

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mul_req_t req_i,
  input  logic             ex_ready_i,
  output ex_pkg::word_t    result_o,
  output logic             multicycle_o,
  output logic             ready_o
);

  localparam int unsigned CNT_W  = $clog2(`EX_MUL_STEPS);
  localparam int unsigned PROD_W = 2 * `EX_XLEN;

  ex_pkg::mul_state_e        state_q, state_d;
  logic [CNT_W-1:0]          cnt_q, cnt_d;   // Step index inside STEP
  logic [CNT_W-1:0]          sel;            // Partial product being added
  logic [PROD_W-1:0]         acc_q;          // Running sum of partial products
  logic [PROD_W-1:0]         acc_sum;
  logic [PROD_W-1:0]         acc_fix;
  logic [PROD_W-1:0]         pp;
  logic [6:0]                pp_shift;
  logic [`EX_MUL_HALF_W-1:0] part_a, part_b;
  ex_pkg::word_t             mag_a, mag_b;
  logic                      is_high, is_signed, neg_res, start;

  assign is_high   = (req_i.op != ex_pkg::MUL_MUL);
  assign is_signed = (req_i.op == ex_pkg::MUL_MULH);
  assign start     = enable_i & is_high & (state_q == ex_pkg::IDLE); // Step 1

  // Work on magnitudes, fix the sign at the end
  assign mag_a   = (is_signed & req_i.op_a[`EX_XLEN-1]) ? -req_i.op_a : req_i.op_a;
  assign mag_b   = (is_signed & req_i.op_b[`EX_XLEN-1]) ? -req_i.op_b : req_i.op_b;
  assign neg_res = is_signed & (req_i.op_a[`EX_XLEN-1] ^ req_i.op_b[`EX_XLEN-1]);

  //////////////////////////////////////////////////////////////////////
  // Partial product datapath
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      ex_pkg::IDLE: sel = '0;
      ex_pkg::STEP: sel = cnt_q;
      default:      sel = CNT_W'(`EX_MUL_STEPS - 1); // Last step lives in DONE
    endcase
  end

  // Bit 0 picks the half of a, bit 1 the half of b
  assign part_a   = sel[0] ? mag_a[`EX_XLEN-1:`EX_MUL_HALF_W] : mag_a[`EX_MUL_HALF_W-1:0];
  assign part_b   = sel[1] ? mag_b[`EX_XLEN-1:`EX_MUL_HALF_W] : mag_b[`EX_MUL_HALF_W-1:0];
  assign pp_shift = (sel[0] + sel[1]) * `EX_MUL_HALF_W;
  assign pp       = PROD_W'(part_a * part_b) << pp_shift;

  assign acc_sum = ((state_q == ex_pkg::IDLE) ? '0 : acc_q) + pp;
  assign acc_fix = neg_res ? -acc_sum : acc_sum;

  // Low word straight from the operands unless a high result is held
  assign result_o = (state_q == ex_pkg::DONE) ? acc_fix[PROD_W-1:`EX_XLEN]
                                              : req_i.op_a * req_i.op_b;

  always_ff @(posedge clk) begin
    if (state_q != ex_pkg::DONE) acc_q <= acc_sum; // Frozen while DONE waits
  end

  //////////////////////////////////////////////////////////////////////
  // Step FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      ex_pkg::IDLE: begin
        if (start) begin
          state_d = ex_pkg::STEP;
          cnt_d   = CNT_W'(1);
        end
      end
      ex_pkg::STEP: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == CNT_W'(`EX_MUL_STEPS - 2)) state_d = ex_pkg::DONE;
      end
      ex_pkg::DONE: begin
        if (ex_ready_i) state_d = ex_pkg::IDLE; // Result taken
      end
      default: state_d = ex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign multicycle_o = (state_q != ex_pkg::IDLE); // High from step 2
  assign ready_o      = (state_q == ex_pkg::DONE) |
                        ((state_q == ex_pkg::IDLE) & ~(enable_i & is_high));

endmodule

/* ex_writeback.sv */
//////////////////////////////////////////////////////////////////////
// ALU-port write mux and the EX/WB load write register
// Load data is not registered, it arrives one cycle after EX
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ex_writeback (
  input  logic             clk,
  input  logic             rst_n,
  input  ex_pkg::id_ctrl_t ctrl_i,
  input  ex_pkg::word_t    alu_result_i,
  input  ex_pkg::word_t    mult_result_i,
  input  ex_pkg::word_t    csr_rdata_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_err_i,
  input  logic             ex_valid_i,
  input  logic             wb_ready_i,
  output ex_pkg::rf_wr_t   fw_port_o,
  output ex_pkg::rf_wr_t   wb_port_o
);

  logic              load_we_q;    // Pending load write
  ex_pkg::reg_addr_t load_waddr_q; // Its destination
  logic              load_we_d;

  //////////////////////////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we    = ctrl_i.regfile_alu_we;
    fw_port_o.waddr = ctrl_i.regfile_alu_waddr;
    // CSR beats MULT beats ALU
    if (ctrl_i.csr_access)   fw_port_o.wdata = csr_rdata_i;
    else if (ctrl_i.mult_en) fw_port_o.wdata = mult_result_i;
    else if (ctrl_i.alu_en)  fw_port_o.wdata = alu_result_i;
    else                     fw_port_o.wdata = '0;
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  assign load_we_d = ctrl_i.regfile_we & ~lsu_err_i; // Faulting load never writes

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_we_q    <= 1'b0;
      load_waddr_q <= '0;
    end else if (ex_valid_i) begin // wb_ready_i already folded in
      load_we_q <= load_we_d;
      if (load_we_d) load_waddr_q <= ctrl_i.regfile_waddr;
    end else if (wb_ready_i) begin
      load_we_q <= 1'b0;           // Nothing new, flush the slot
    end
  end

  assign wb_port_o.we    = load_we_q;
  assign wb_port_o.waddr = load_waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

endmodule

/* ex_stage.sv */
//////////////////////////////////////////////////////////////////////
// Execute stage top, ALU, multiplier and write ports
// Decode must hold its inputs while ex_ready_o is low
// A branch in EX releases the stage without waiting on WB
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ex_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  ex_pkg::id_ctrl_t id_ctrl_i,
  input  ex_pkg::alu_req_t alu_req_i,
  input  ex_pkg::mul_req_t mul_req_i,
  input  ex_pkg::word_t    csr_rdata_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,  // EX half of the LSU is done
  input  logic             lsu_err_i,
  input  logic             wb_ready_i,
  output ex_pkg::rf_wr_t   fw_port_o,       // ALU / MULT / CSR write
  output ex_pkg::rf_wr_t   wb_port_o,       // Load write
  output ex_pkg::word_t    jump_target_o,
  output logic             branch_decision_o,
  output logic             mult_multicycle_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  ex_pkg::word_t alu_result;
  ex_pkg::word_t mult_result;
  logic          alu_cmp;
  logic          mult_ready;
  logic          units_ready;
  logic          any_en;

  ex_alu alu0 (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult mult0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (id_ctrl_i.mult_en),
    .req_i        (mul_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback wb0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (id_ctrl_i),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .lsu_err_i     (lsu_err_i),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Handshake, valid forward and ready back
  //////////////////////////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = id_ctrl_i.alu_en | id_ctrl_i.mult_en |
                       id_ctrl_i.csr_access | id_ctrl_i.lsu_en;

  assign ex_ready_o = units_ready | id_ctrl_i.branch_in_ex; // Branch ends in EX
  assign ex_valid_o = any_en & units_ready;                 // No ex_ready term

  // Branch outputs straight from the ALU compare and operand c
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.operand_c;

endmodule

/* tb_ex_stage.sv */
//////////////////////////////////////////////////////////////////////
// Random-stimulus testbench for the execute stage
// Stalls on wb_ready / lsu_ready are random
// Decode holds each instruction until the DUT takes it
// Run is bounded by a cycle counter sized from the instruction count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_ex_stage;

  localparam int NUM_INSTR   = 400;
  localparam int CYCLE_LIMIT = NUM_INSTR * 12; // Worst case incl. MULH and stalls

  logic             clk;
  logic             rst_n;
  ex_pkg::id_ctrl_t ctrl;
  ex_pkg::alu_req_t areq;
  ex_pkg::mul_req_t mreq;
  ex_pkg::word_t    csr_rdata, lsu_rdata, jump_target;
  logic             lsu_ready, lsu_err, wb_ready;
  ex_pkg::rf_wr_t   fw_port, wb_port;
  logic             branch_dec, mult_multi, ex_ready, ex_valid;

  logic [31:0] lcg_state = 32'd65265;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          mstep  = 0;   // Cycles a high multiply has already spent in EX
  logic        wb_we_m = 1'b0;
  logic [5:0]  wb_waddr_m = '0;
  logic        accepted;

  ex_stage dut0 (
    .clk (clk), .rst_n (rst_n),
    .id_ctrl_i (ctrl), .alu_req_i (areq), .mul_req_i (mreq),
    .csr_rdata_i (csr_rdata), .lsu_rdata_i (lsu_rdata),
    .lsu_ready_ex_i (lsu_ready), .lsu_err_i (lsu_err), .wb_ready_i (wb_ready),
    .fw_port_o (fw_port), .wb_port_o (wb_port), .jump_target_o (jump_target),
    .branch_decision_o (branch_dec), .mult_multicycle_o (mult_multi),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_word(); // Built from the stronger upper halves
    logic [31:0] hi, lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic logic cmp_model(input logic [3:0] op, input logic [31:0] a, b);
    logic lt_u, lt_s;
    lt_u = (a < b);
    lt_s = (a[31] != b[31]) ? a[31] : lt_u; // Negative operand is less when signs differ
    case (op)
      4'd8, 4'd12:  return lt_s;  // SLT, LT
      4'd9, 4'd14:  return lt_u;  // SLTU, LTU
      4'd10:        return (a == b);
      4'd11:        return (a != b);
      4'd13:        return !lt_s;
      4'd15:        return !lt_u;
      default:      return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a, b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      4'd0:    return a + b;
      4'd1:    return a - b;
      4'd2:    return a & b;
      4'd3:    return a | b;
      4'd4:    return a ^ b;
      4'd5:    return a << sh;
      4'd6:    return a >> sh;
      4'd7:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0); // Sign fill
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  function automatic logic [31:0] mul_model(input logic [1:0] op, input logic [31:0] a, b);
    logic [63:0] p;
    if (op == 2'd1) p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    else            p = {32'b0, a} * {32'b0, b};
    return (op == 2'd0) ? p[31:0] : p[63:32];
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic issue_instr();
    ex_pkg::id_ctrl_t c;
    ex_pkg::alu_req_t a;
    ex_pkg::mul_req_t m;
    int               kind;
    c = '0;
    a.operand_a = rand_word();
    a.operand_b = rand_word();
    a.operand_c = rand_word();
    a.op        = ex_pkg::alu_op_e'(4'(rand_word() % 10));
    m.op_a      = rand_word();
    m.op_b      = rand_word();
    m.op        = ex_pkg::MUL_MUL;
    kind        = rand_word() % 9;
    case (kind)
      0, 1, 2: begin
        c.alu_en         = 1'b1;
        c.regfile_alu_we = 1'b1;
      end
      3: begin // Branch with equal operands half the time
        c.alu_en       = 1'b1;
        c.branch_in_ex = 1'b1;
        a.op           = ex_pkg::alu_op_e'(4'(10 + rand_word() % 6));
        if (rand_word() % 2 == 0) a.operand_b = a.operand_a;
      end
      4: begin
        c.mult_en        = 1'b1;
        c.regfile_alu_we = 1'b1;
      end
      5: begin
        c.mult_en        = 1'b1;
        c.regfile_alu_we = 1'b1;
        m.op = (rand_word() % 2 == 0) ? ex_pkg::MUL_MULH : ex_pkg::MUL_MULHU;
      end
      6: begin
        c.csr_access     = 1'b1;
        c.alu_en         = 1'b1;
        c.mult_en        = 1'b1;
        c.regfile_alu_we = 1'b1;
      end
      7: begin
        c.lsu_en     = 1'b1;
        c.regfile_we = 1'b1;
      end
      default: ;               // Bubble with nothing enabled
    endcase
    c.regfile_alu_waddr = 6'(rand_word() % 64);
    c.regfile_waddr     = 6'(rand_word() % 64);
    ctrl      <= c;
    areq      <= a;
    mreq      <= m;
    csr_rdata <= rand_word();
  endtask

  task automatic drive_stalls();
    wb_ready  <= (rand_word() % 4) != 0;
    lsu_ready <= (rand_word() % 8) != 0;
    lsu_err   <= (rand_word() % 4) == 0;
    lsu_rdata <= rand_word();
  endtask

  // Compare one cycle against the model and advance its state
  task automatic verify_cycle();
    logic        hi_mul, units, exp_ready, exp_valid;
    logic [31:0] exp_fw;
    hi_mul    = ctrl.mult_en && (mreq.op != ex_pkg::MUL_MUL);
    units     = (!hi_mul || mstep >= 3) && lsu_ready && wb_ready; // Step 4 frees mult
    exp_ready = units || ctrl.branch_in_ex;
    exp_valid = (ctrl.alu_en || ctrl.mult_en || ctrl.csr_access || ctrl.lsu_en) && units;
    check_eq(ex_ready, exp_ready, "ex_ready_o");
    check_eq(ex_valid, exp_valid, "ex_valid_o");
    check_eq(mult_multi, hi_mul && mstep >= 1, "mult_multicycle_o");
    check_eq(jump_target, areq.operand_c, "jump_target_o");
    if (ctrl.branch_in_ex)
      check_eq(branch_dec, cmp_model(areq.op, areq.operand_a, areq.operand_b), "branch");
    check_eq(wb_port.we, wb_we_m, "wb_port_o.we");
    if (wb_we_m) check_eq(wb_port.waddr, wb_waddr_m, "wb_port_o.waddr");
    check_eq(wb_port.wdata, lsu_rdata, "wb_port_o.wdata");
    if (exp_ready) begin
      if (ctrl.csr_access)   exp_fw = csr_rdata;
      else if (ctrl.mult_en) exp_fw = mul_model(mreq.op, mreq.op_a, mreq.op_b);
      else if (ctrl.alu_en)  exp_fw = alu_model(areq.op, areq.operand_a, areq.operand_b);
      else                   exp_fw = '0;
      check_eq(fw_port.wdata, exp_fw, "fw_port_o.wdata");
      check_eq(fw_port.we, ctrl.regfile_alu_we, "fw_port_o.we");
      check_eq(fw_port.waddr, ctrl.regfile_alu_waddr, "fw_port_o.waddr");
    end
    if (exp_valid) begin   // EX/WB capture with the error masking the write
      wb_we_m = ctrl.regfile_we && !lsu_err;
      if (wb_we_m) wb_waddr_m = ctrl.regfile_waddr;
    end else if (wb_ready) begin
      wb_we_m = 1'b0;
    end
    accepted = (ex_ready === 1'b1); // Decode moves on when the DUT takes the instruction
    if (accepted) mstep = 0;
    else if (hi_mul) mstep++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    int done_cnt;
    done_cnt  = 0;
    rst_n     = 1'b0;
    ctrl      = '0;
    areq      = '0;
    mreq      = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    lsu_ready = 1'b1;
    lsu_err   = 1'b0;
    wb_ready  = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq(wb_port.we, 1'b0, "wb_port_o.we after reset");
    check_eq(mult_multi, 1'b0, "mult_multicycle_o after reset");
    @(posedge clk);
    issue_instr();
    drive_stalls();
    while (done_cnt < NUM_INSTR) begin
      @(negedge clk);      // Inputs settled since the last rising edge
      verify_cycle();
      @(posedge clk);
      if (accepted) begin
        done_cnt++;
        if (done_cnt < NUM_INSTR) issue_instr();
      end
      drive_stalls();
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
      end
    end
  end

endmodule

/* src.f */
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv
